//--- rtl/cp0_reg_pkg.sv
package cp0_reg_pkg;

    typedef logic [31:0] word_t;

    // implemented CP0 register numbers
    typedef enum logic [4:0] {
        BADVADDR = 5'd8,
        COUNT    = 5'd9,
        COMPARE  = 5'd11,
        STATUS   = 5'd12,
        CAUSE    = 5'd13,
        EPC      = 5'd14,
        CONFIG   = 5'd16
    } creg_addr_t;

    typedef struct packed {
        logic [8:0] zero_31_23;
        logic       bev;
        logic [5:0] zero_21_16;
        logic [7:0] im;
        logic [4:0] zero_7_3;
        logic       erl;
        logic       exl;
        logic       ie;
    } cp0_status_t;

    typedef struct packed {
        logic        bd;
        logic        ti;
        logic [13:0] zero_29_16;
        logic [7:0]  ip;
        logic        zero_7;
        logic [4:0]  exccode;
        logic [1:0]  zero_1_0;
    } cp0_cause_t;

    typedef struct packed {
        word_t       badvaddr;
        word_t       count;
        word_t       compare;
        cp0_status_t status;
        cp0_cause_t  cause;
        word_t       epc;
        word_t       config_;
    } cp0_regs_t;

    // bev and erl set out of reset
    localparam cp0_status_t STATUS_RESET = cp0_status_t'(32'h0040_0004);
    localparam word_t       CONFIG_VALUE = 32'h8000_0000;

    localparam cp0_regs_t CP0_RESET = '{
        badvaddr: '0,
        count:    '0,
        compare:  '0,
        status:   STATUS_RESET,
        cause:    '0,
        epc:      '0,
        config_:  CONFIG_VALUE
    };

endpackage

//--- rtl/commit_pkg.sv
package commit_pkg;

    import cp0_reg_pkg::*;

    // Cause.ExcCode values
    typedef enum logic [4:0] {
        INT  = 5'd0,
        ADEL = 5'd4,
        ADES = 5'd5,
        SYS  = 5'd8,
        BP   = 5'd9,
        RI   = 5'd10,
        OV   = 5'd12
    } exc_code_t;

    // one mtc0 port
    typedef struct packed {
        logic       wen;
        creg_addr_t addr;
        word_t      wd;
    } cwrite_t;

    typedef struct packed {
        logic      valid;
        exc_code_t code;
        word_t     pc;
        logic      in_delay_slot;
        word_t     badvaddr;
    } exception_t;

    // instruction leaving the commit stage
    typedef struct packed {
        logic      valid;
        word_t     pc;
        logic      in_delay_slot;
        logic      exc_valid;
        exc_code_t exc_code;
        word_t     badvaddr;
        logic      is_eret;
        cwrite_t   cwrite;
    } commit_t;

    localparam word_t EXC_VECTOR_BEV = 32'hBFC0_0380;
    localparam word_t EXC_VECTOR     = 32'h8000_0180;

endpackage

//--- rtl/cp0.sv
`timescale 1ns/1ps

module cp0 (
    input  logic                          clk,
    input  logic                          reset,
    input  commit_pkg::cwrite_t [1:0]     cwrite,
    input  cp0_reg_pkg::creg_addr_t [1:0] ra,
    output cp0_reg_pkg::word_t [1:0]      rd,
    input  logic                          is_eret,
    input  commit_pkg::exception_t        exception,
    input  logic [5:0]                    hw_int,
    output cp0_reg_pkg::word_t            epc,
    output logic                          timer_interrupt,
    output cp0_reg_pkg::cp0_status_t      cp0_status,
    output cp0_reg_pkg::cp0_cause_t       cp0_cause
);

    import cp0_reg_pkg::*;
    import commit_pkg::*;

    cp0_regs_t cp0_q;
    cp0_regs_t cp0_next;
    logic      count_tick;
    logic      compare_wr;

    function automatic word_t read_reg(cp0_regs_t r, creg_addr_t a);
        word_t v;
        case (a)
            BADVADDR: v = r.badvaddr;
            COUNT:    v = r.count;
            COMPARE:  v = r.compare;
            STATUS:   v = r.status;
            CAUSE:    v = r.cause;
            EPC:      v = r.epc;
            CONFIG:   v = r.config_;
            default:  v = '0;
        endcase
        return v;
    endfunction

    // one mtc0 moves only the writable fields
    function automatic cp0_regs_t apply_write(cp0_regs_t r, cwrite_t w);
        cp0_regs_t   n;
        cp0_status_t ws;
        cp0_cause_t  wc;
        n  = r;
        ws = cp0_status_t'(w.wd);
        wc = cp0_cause_t'(w.wd);
        if (w.wen) begin
            case (w.addr)
                COUNT:   n.count = w.wd;
                COMPARE: n.compare = w.wd;
                STATUS: begin
                    n.status.im  = ws.im;
                    n.status.exl = ws.exl;
                    n.status.ie  = ws.ie;
                end
                CAUSE:   n.cause.ip[1:0] = wc.ip[1:0];
                EPC:     n.epc = w.wd;
                default: ;
            endcase
        end
        return n;
    endfunction

    // read ports see the registered state
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            rd[i] = read_reg(cp0_q, ra[i]);
        end
    end

    assign compare_wr = (cwrite[1].wen && cwrite[1].addr == COMPARE) ||
                        (cwrite[0].wen && cwrite[0].addr == COMPARE);

    always_comb begin
        cp0_next = cp0_q;

        // count at half the clock rate
        cp0_next.count = cp0_q.count + {31'b0, count_tick};

        cp0_next.cause.ip[7:2] = {hw_int[5] | timer_interrupt, hw_int[4:0]};
        cp0_next.cause.ti      = timer_interrupt;

        // older slot first so the younger write wins
        cp0_next = apply_write(cp0_next, cwrite[1]);
        cp0_next = apply_write(cp0_next, cwrite[0]);

        if (exception.valid) begin
            // nested exception keeps the first epc
            if (!cp0_q.status.exl) begin
                if (exception.in_delay_slot) begin
                    cp0_next.cause.bd = 1'b1;
                    cp0_next.epc      = exception.pc - 32'd4;
                end else begin
                    cp0_next.cause.bd = 1'b0;
                    cp0_next.epc      = exception.pc;
                end
            end
            cp0_next.cause.exccode = exception.code;
            cp0_next.status.exl    = 1'b1;
            if (exception.code == ADEL || exception.code == ADES) begin
                cp0_next.badvaddr = exception.badvaddr;
            end
        end

        if (is_eret) begin
            if (cp0_q.status.erl) begin
                cp0_next.status.erl = 1'b0;
            end else begin
                cp0_next.status.exl = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cp0_q <= CP0_RESET;
        end else begin
            cp0_q <= cp0_next;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count_tick <= 1'b0;
        end else begin
            count_tick <= ~count_tick;
        end
    end

    // timer stays set until compare is rewritten
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            timer_interrupt <= 1'b0;
        end else if (compare_wr) begin
            timer_interrupt <= 1'b0;
        end else if (cp0_next.count == cp0_next.compare) begin
            timer_interrupt <= 1'b1;
        end
    end

    assign epc        = cp0_q.epc;
    assign cp0_status = cp0_q.status;
    assign cp0_cause  = cp0_q.cause;

    // exc_commit must never take both in one cycle
    a_exc_eret_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(exception.valid && is_eret)
    );

endmodule

//--- rtl/exc_commit.sv
`timescale 1ns/1ps

module exc_commit (
    input  logic                       clk,
    input  logic                       reset,
    input  commit_pkg::commit_t [1:0]  commit,
    input  cp0_reg_pkg::cp0_status_t   cp0_status,
    input  cp0_reg_pkg::cp0_cause_t    cp0_cause,
    input  cp0_reg_pkg::word_t         epc,
    output commit_pkg::exception_t     exception,
    output commit_pkg::cwrite_t [1:0]  cwrite,
    output logic                       is_eret,
    output logic                       redirect_valid,
    output cp0_reg_pkg::word_t         redirect_pc
);

    import cp0_reg_pkg::*;
    import commit_pkg::*;

    logic  any_commit;
    logic  int_req;
    logic  int1;
    logic  int0;
    logic  trap1;
    logic  trap0;
    logic  eret1;
    logic  eret0;
    logic  alive0;
    word_t vector;

    function automatic exception_t make_exception(commit_t c, logic irq);
        exception_t e;
        e.valid         = 1'b1;
        e.code          = irq ? INT : c.exc_code;
        e.pc            = c.pc;
        e.in_delay_slot = c.in_delay_slot;
        e.badvaddr      = c.badvaddr;
        return e;
    endfunction

    assign any_commit = commit[1].valid | commit[0].valid;

    // pending and enabled interrupt needs a commit to attach to
    assign int_req = (|(cp0_cause.ip & cp0_status.im)) && cp0_status.ie &&
                     !cp0_status.exl && !cp0_status.erl && any_commit;

    // goes to the older valid slot
    assign int1 = int_req && commit[1].valid;
    assign int0 = int_req && !commit[1].valid;

    assign trap1 = commit[1].valid && (commit[1].exc_valid || int1);
    assign trap0 = commit[0].valid && (commit[0].exc_valid || int0);

    assign eret1  = commit[1].valid && commit[1].is_eret && !trap1;
    // slot 0 is dropped behind a trap or an eret in slot 1
    assign alive0 = !trap1 && !eret1;
    assign eret0  = commit[0].valid && commit[0].is_eret && !trap0 && alive0;

    assign is_eret = eret1 | eret0;

    always_comb begin
        exception = '0;
        if (trap1) begin
            exception = make_exception(commit[1], int1);
        end else if (alive0 && trap0) begin
            exception = make_exception(commit[0], int0);
        end
    end

    always_comb begin
        cwrite[1]     = commit[1].cwrite;
        cwrite[0]     = commit[0].cwrite;
        cwrite[1].wen = commit[1].cwrite.wen && commit[1].valid && !trap1;
        cwrite[0].wen = commit[0].cwrite.wen && commit[0].valid && alive0 && !trap0;
    end

    assign vector = cp0_status.bev ? EXC_VECTOR_BEV : EXC_VECTOR;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= exception.valid | is_eret;
        end
    end

    // eret returns to epc as it was before this cycle
    always_ff @(posedge clk) begin
        if (exception.valid) begin
            redirect_pc <= vector;
        end else if (is_eret) begin
            redirect_pc <= epc;
        end
    end

endmodule

//--- rtl/cp0_top.sv
`timescale 1ns/1ps

module cp0_top (
    input  logic                          clk,
    input  logic                          reset,
    input  commit_pkg::commit_t [1:0]     commit,
    input  cp0_reg_pkg::creg_addr_t [1:0] ra,
    input  logic [5:0]                    hw_int,
    output cp0_reg_pkg::word_t [1:0]      rd,
    output cp0_reg_pkg::word_t            epc,
    output logic                          timer_interrupt,
    output logic                          redirect_valid,
    output cp0_reg_pkg::word_t            redirect_pc
);

    import cp0_reg_pkg::*;
    import commit_pkg::*;

    exception_t    exception;
    cwrite_t [1:0] cwrite;
    logic          is_eret;
    cp0_status_t   cp0_status;
    cp0_cause_t    cp0_cause;

    exc_commit u_exc_commit (
        .clk            (clk),
        .reset          (reset),
        .commit         (commit),
        .cp0_status     (cp0_status),
        .cp0_cause      (cp0_cause),
        .epc            (epc),
        .exception      (exception),
        .cwrite         (cwrite),
        .is_eret        (is_eret),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    cp0 u_cp0 (
        .clk             (clk),
        .reset           (reset),
        .cwrite          (cwrite),
        .ra              (ra),
        .rd              (rd),
        .is_eret         (is_eret),
        .exception       (exception),
        .hw_int          (hw_int),
        .epc             (epc),
        .timer_interrupt (timer_interrupt),
        .cp0_status      (cp0_status),
        .cp0_cause       (cp0_cause)
    );

endmodule

//--- bench/tb_cp0.sv
`timescale 1ns/1ps

module tb_cp0;

    import cp0_reg_pkg::*;
    import commit_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int MAX_CYCLES = 2000;

    logic          clk;
    logic          reset;
    commit_t [1:0] commit;
    creg_addr_t [1:0] ra;
    logic [5:0]    hw_int;
    word_t [1:0]   rd;
    word_t         epc;
    logic          timer_interrupt;
    logic          redirect_valid;
    word_t         redirect_pc;

    int          errors;
    logic [31:0] rng;

    // expected architectural state
    word_t       m_badvaddr, m_count, m_compare, m_epc;
    logic        m_bev, m_erl, m_exl, m_ie, m_bd, m_ti, m_tick, m_timer, m_rv;
    logic [7:0]  m_im, m_ip;
    logic [4:0]  m_exc;
    word_t       m_rpc;
    logic        wr_cmp;
    word_t       m_status_w, m_cause_w;
    word_t [1:0] exp_rd;

    cp0_top uut (
        .clk             (clk),
        .reset           (reset),
        .commit          (commit),
        .ra              (ra),
        .hw_int          (hw_int),
        .rd              (rd),
        .epc             (epc),
        .timer_interrupt (timer_interrupt),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic creg_addr_t addr_of(int idx);
        case (idx)
            0: return BADVADDR;
            1: return COUNT;
            2: return COMPARE;
            3: return STATUS;
            4: return CAUSE;
            5: return EPC;
            6: return CONFIG;
            default: return creg_addr_t'(5'd3);
        endcase
    endfunction

    assign m_status_w = {9'b0, m_bev, 6'b0, m_im, 5'b0, m_erl, m_exl, m_ie};
    assign m_cause_w  = {m_bd, m_ti, 14'b0, m_ip, 1'b0, m_exc, 2'b0};

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            case (ra[i])
                BADVADDR: exp_rd[i] = m_badvaddr;
                COUNT:    exp_rd[i] = m_count;
                COMPARE:  exp_rd[i] = m_compare;
                STATUS:   exp_rd[i] = m_status_w;
                CAUSE:    exp_rd[i] = m_cause_w;
                EPC:      exp_rd[i] = m_epc;
                CONFIG:   exp_rd[i] = 32'h8000_0000;
                default:  exp_rd[i] = '0;
            endcase
        end
    end

    task automatic model_write(cwrite_t w);
        case (w.addr)
            COUNT:   m_count = w.wd;
            COMPARE: begin
                m_compare = w.wd;
                wr_cmp    = 1'b1;
            end
            STATUS: begin
                m_im  = w.wd[15:8];
                m_exl = w.wd[1];
                m_ie  = w.wd[0];
            end
            CAUSE:   m_ip[1:0] = w.wd[9:8];
            EPC:     m_epc = w.wd;
            default: ;
        endcase
    endtask

    always @(posedge clk or posedge reset) begin
        logic    pending, t1, t0, e1, e0, keep0, old_exl, old_erl, old_timer, take;
        word_t   old_epc;
        commit_t c;
        if (reset) begin
            {m_badvaddr, m_count, m_compare, m_epc} = '0;
            {m_bev, m_erl, m_exl, m_ie} = 4'b1100;
            {m_bd, m_ti, m_tick, m_timer, m_rv} = '0;
            m_im  = '0;
            m_ip  = '0;
            m_exc = '0;
        end else begin
            old_exl   = m_exl;
            old_erl   = m_erl;
            old_epc   = m_epc;
            old_timer = m_timer;
            pending = (|(m_ip & m_im)) && m_ie && !m_exl && !m_erl &&
                      (commit[1].valid || commit[0].valid);
            t1 = commit[1].valid && (commit[1].exc_valid || pending);
            t0 = commit[0].valid && (commit[0].exc_valid || (pending && !commit[1].valid));
            e1 = commit[1].valid && commit[1].is_eret && !t1;
            keep0 = !t1 && !e1;
            e0 = keep0 && commit[0].valid && commit[0].is_eret && !t0;
            wr_cmp = 1'b0;
            if (m_tick) begin
                m_count = m_count + 1;
            end
            m_tick    = ~m_tick;
            m_ip[7:2] = {hw_int[5] | old_timer, hw_int[4:0]};
            m_ti      = old_timer;
            if (commit[1].valid && commit[1].cwrite.wen && !t1) begin
                model_write(commit[1].cwrite);
            end
            if (keep0 && commit[0].valid && commit[0].cwrite.wen && !t0) begin
                model_write(commit[0].cwrite);
            end
            take = t1 || (keep0 && t0);
            c = t1 ? commit[1] : commit[0];
            if (take) begin
                if (!old_exl) begin
                    m_bd  = c.in_delay_slot;
                    m_epc = c.in_delay_slot ? c.pc - 32'd4 : c.pc;
                end
                m_exc = pending ? 5'd0 : c.exc_code;
                m_exl = 1'b1;
                if (!pending && (c.exc_code == ADEL || c.exc_code == ADES)) begin
                    m_badvaddr = c.badvaddr;
                end
            end
            if (e1 || e0) begin
                if (old_erl) begin
                    m_erl = 1'b0;
                end else begin
                    m_exl = 1'b0;
                end
            end
            m_rv = take || e1 || e0;
            if (take) begin
                m_rpc = m_bev ? 32'hBFC0_0380 : 32'h8000_0180;
            end else if (e1 || e0) begin
                m_rpc = old_epc;
            end
            if (wr_cmp) begin
                m_timer = 1'b0;
            end else if (m_count == m_compare) begin
                m_timer = 1'b1;
            end
        end
    end

    a_rd0: assert property (@(posedge clk) disable iff (reset) rd[0] == exp_rd[0])
        else begin
            errors++;
            $display("mismatch rd[0] got %h expected %h", $sampled(rd[0]), $sampled(exp_rd[0]));
        end

    a_rd1: assert property (@(posedge clk) disable iff (reset) rd[1] == exp_rd[1])
        else begin
            errors++;
            $display("mismatch rd[1] got %h expected %h", $sampled(rd[1]), $sampled(exp_rd[1]));
        end

    a_epc: assert property (@(posedge clk) disable iff (reset) epc == m_epc)
        else begin
            errors++;
            $display("mismatch epc got %h expected %h", $sampled(epc), $sampled(m_epc));
        end

    a_timer: assert property (@(posedge clk) disable iff (reset) timer_interrupt == m_timer)
        else begin
            errors++;
            $display("mismatch timer_interrupt got %h expected %h",
                     $sampled(timer_interrupt), $sampled(m_timer));
        end

    a_redirect_valid: assert property (@(posedge clk) disable iff (reset) redirect_valid == m_rv)
        else begin
            errors++;
            $display("mismatch redirect_valid got %h expected %h",
                     $sampled(redirect_valid), $sampled(m_rv));
        end

    a_redirect_pc: assert property (
        @(posedge clk) disable iff (reset) redirect_valid |-> redirect_pc == m_rpc)
        else begin
            errors++;
            $display("mismatch redirect_pc got %h expected %h",
                     $sampled(redirect_pc), $sampled(m_rpc));
        end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // one commit pair held for a single cycle, read ports wander
    task automatic issue(commit_t c1, commit_t c0);
        commit[1] = c1;
        commit[0] = c0;
        rng = xorshift(rng);
        ra[0] = addr_of(rng[2:0]);
        ra[1] = addr_of(rng[6:4]);
        step();
        commit = '0;
    endtask

    function automatic commit_t mk_write(creg_addr_t a, word_t d, word_t pc);
        commit_t c;
        c = '0;
        c.valid = 1'b1;
        c.pc = pc;
        c.cwrite.wen = 1'b1;
        c.cwrite.addr = a;
        c.cwrite.wd = d;
        return c;
    endfunction

    function automatic commit_t mk_exc(exc_code_t code, word_t pc, logic ds, word_t bva);
        commit_t c;
        c = '0;
        c.valid = 1'b1;
        c.pc = pc;
        c.in_delay_slot = ds;
        c.exc_valid = 1'b1;
        c.exc_code = code;
        c.badvaddr = bva;
        return c;
    endfunction

    function automatic commit_t mk_eret(word_t pc);
        commit_t c;
        c = '0;
        c.valid = 1'b1;
        c.pc = pc;
        c.is_eret = 1'b1;
        return c;
    endfunction

    initial begin
        #(MAX_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles", MAX_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        commit_t    c1, c0;
        creg_addr_t a;
        int         n;
        errors = 0;
        rng    = 32'd74267;
        reset  = 1'b1;
        commit = '0;
        hw_int = '0;
        ra[0]  = STATUS;
        ra[1]  = CONFIG;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        step();
        ra[0] = creg_addr_t'(5'd3);
        ra[1] = creg_addr_t'(5'd3);
        step();

        // random mtc0 traffic, sometimes both slots on one register
        for (int i = 0; i < 60; i++) begin
            rng = xorshift(rng);
            a = addr_of(rng[1:0] + 2);
            c1 = mk_write(a, xorshift(rng), {rng[31:2], 2'b00});
            rng = xorshift(rng);
            c0 = mk_write(rng[0] ? a : addr_of(rng[2:1] + 2), rng, {rng[31:2], 2'b00});
            issue(c1, c0);
        end
        issue(mk_write(STATUS, 32'h0, 32'h100), mk_write(COMPARE, 32'hFFFF_0000, 32'h104));

        // exception on slot 1, squashed slot 0 write, then a nested one
        rng = xorshift(rng);
        issue(mk_exc(ADEL, 32'h0040_1000, 1'b1, rng), mk_write(EPC, 32'h1234_5678, 32'h0));
        issue(mk_exc(SYS, 32'h0040_2000, 1'b0, 32'hDEAD_0000), '0);
        // two erets, erl first then exl, younger write dropped
        issue(mk_eret(32'h0040_3000), mk_write(EPC, 32'hCAFE_0000, 32'h0));
        issue(mk_eret(32'h0040_3004), mk_write(COMPARE, 32'h0, 32'h0));
        issue('0, mk_exc(ADES, 32'h0040_4000, 1'b0, 32'h0000_0BAD));
        issue('0, mk_exc(BP, 32'h0040_5000, 1'b0, 32'h0000_0F00));
        issue(mk_eret(32'h0040_6000), '0);

        // counter and timer
        ra[0] = COUNT;
        ra[1] = CAUSE;
        repeat (4) step();
        issue(mk_write(COMPARE, m_count + 32'd5, 32'h200), '0);
        n = 0;
        while (!timer_interrupt && n < 30) begin
            step();
            n++;
        end
        if (!timer_interrupt) begin
            errors++;
            $display("timer interrupt did not rise after compare was written");
        end
        issue(mk_write(COMPARE, 32'h0000_0FFF, 32'h204), '0);
        step();

        // hardware interrupt, enabled and then masked by ie
        issue(mk_write(STATUS, 32'h0000_0401, 32'h300), '0);
        hw_int = 6'b000001;
        repeat (3) step();
        issue(mk_write(EPC, 32'h0, 32'h0040_7000), '0);
        step();
        issue(mk_write(STATUS, 32'h0000_0400, 32'h304), '0);
        issue(mk_write(EPC, 32'h5555_0000, 32'h0040_8000), '0);
        hw_int = '0;
        repeat (4) step();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
rtl/cp0_reg_pkg.sv
rtl/commit_pkg.sv
rtl/cp0.sv
rtl/exc_commit.sv
rtl/cp0_top.sv
bench/tb_cp0.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cp0 -f files.f -o sim_tb_cp0

./obj_dir/sim_tb_cp0 > sim.log 2>&1 || true
cat sim.log

grep -qx "TEST OK" sim.log
